// File: compile.f
+incdir+common
common/uart_pkg.sv
rtl/uart_baud.sv
uart_rx/uart_rx.sv
uart_tx/uart_tx.sv
rtl/uart_regs.sv
rtl/uart_top.sv
test/uart_assert.sv
test/uart_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log

verilator --binary --timing --assert -f compile.f --top-module uart_tb \
  -Mdir obj_dir -o uart_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/uart_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// File: test/uart_tb.sv
`default_nettype none

`include "uart_defines.svh"

module uart_tb;

  import uart_pkg::*;

  localparam int DIV        = 2;
  localparam int BIT_CYC    = `UART_OVERSAMPLE * DIV;
  localparam int HALF_CYC   = BIT_CYC / 2;
  // a bad stop bit held just past its middle, so the line is high again at the next start check
  localparam int SHORT_STOP = (`UART_OVERSAMPLE / 2 + 1) * DIV;

  logic        sys_clk;
  logic        sys_rst_l;
  logic        reg_wr;
  logic        reg_rd;
  reg_addr_t   reg_addr;
  logic [15:0] reg_wdata;
  logic [15:0] reg_rdata;
  logic        rxd;
  logic        txd;
  logic        irq;

  int          cycle_cnt;
  logic [31:0] lcg_state;
  string       test_name;
  int          test_err_start;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;

  uart_top UUT (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .rxd       (rxd),
    .txd       (txd),
    .irq       (irq)
  );

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;
  end

  always @(posedge sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic logic [7:0] rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  function automatic int bound_failures();
    return UUT.u_chk.tx_idle_errs + UUT.u_chk.ready_len_errs + UUT.u_chk.start_busy_errs
      + UUT.u_chk.irq_rise_errs;
  endfunction

  task automatic begin_test(input string name);
    test_name      = name;
    test_err_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_err_start) begin
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - test_err_start);
    end
  endtask

  task automatic check_value(input string what, input logic [15:0] exp,
                             input logic [15:0] act);
    checks++;
    assert (act === exp) else begin
      $display("[ERROR] %s: %s expected 0x%04h actual 0x%04h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input logic [15:0] data);
    @(posedge sys_clk);
    reg_wr    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge sys_clk);
    reg_wr    <= 1'b0;
  endtask

  // read data is registered, so it is taken one cycle after the strobe
  task automatic read_reg(input reg_addr_t addr, output logic [15:0] data);
    @(posedge sys_clk);
    reg_rd   <= 1'b1;
    reg_addr <= addr;
    @(posedge sys_clk);
    reg_rd   <= 1'b0;
    @(negedge sys_clk);
    data = reg_rdata;
  endtask

  task automatic wait_irq(input logic level, input int max_cycles);
    int n;
    n = 0;
    while (irq !== level && n < max_cycles) begin
      @(negedge sys_clk);
      n++;
    end
    if (irq !== level) begin
      $display("%s: irq did not become %0d within %0d cycles", test_name, level, max_cycles);
      errors++;
    end
  endtask

  task automatic wait_txd(input logic level, input int max_cycles);
    int n;
    n = 0;
    do begin
      @(negedge sys_clk);
      n++;
    end while (txd !== level && n < max_cycles);
    if (txd !== level) begin
      $display("%s: txd did not become %0d within %0d cycles", test_name, level, max_cycles);
      errors++;
    end
  endtask

  task automatic wait_until_cycle(input int target);
    int n;
    n = 0;
    while (cycle_cnt < target && n < 4 * BIT_CYC) begin
      @(negedge sys_clk);
      n++;
    end
    if (cycle_cnt < target) begin
      $display("%s: cycle %0d was not reached in time", test_name, target);
      errors++;
    end
  endtask

  task automatic drive_rxd(input logic level, input int ncycles);
    @(posedge sys_clk);
    rxd <= level;
    repeat (ncycles - 1) @(posedge sys_clk);
  endtask

  task automatic send_frame(input logic [7:0] data, input logic stop_ok);
    int i;
    drive_rxd(1'b0, BIT_CYC);
    for (i = 0; i < `UART_WORD_LEN; i++) begin
      drive_rxd(data[i], BIT_CYC);
    end
    if (stop_ok) begin
      drive_rxd(1'b1, BIT_CYC);
    end else begin
      drive_rxd(1'b0, SHORT_STOP);
    end
    drive_rxd(1'b1, BIT_CYC);
  endtask

  initial begin
    logic [15:0] rd;
    logic [7:0]  b1;
    logic [7:0]  b2;
    int          fall_cyc;
    int          k;
    int          fails;
    logic        exp_bit;
    sys_rst_l = 1'b0;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    reg_addr  = ADDR_DIV;
    reg_wdata = 16'h0000;
    rxd       = 1'b1;
    cycle_cnt = 0;
    lcg_state = 32'h7500_fb0d;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (2) @(posedge sys_clk);
    sys_rst_l <= 1'b1;

    begin_test("reset");
    @(negedge sys_clk);
    check_value("txd", 16'h0001, 16'(txd));
    check_value("irq", 16'h0000, 16'(irq));
    read_reg(ADDR_STATUS, rd);
    check_value("status", 16'h0000, rd);
    end_test();

    write_reg(ADDR_DIV, 16'(DIV));

    begin_test("transmit");
    b1 = rand_byte();
    write_reg(ADDR_TXDATA, 16'(b1));
    wait_txd(1'b0, 2);
    fall_cyc = cycle_cnt;
    for (k = 0; k < `UART_WORD_LEN + 2; k++) begin
      wait_until_cycle(fall_cyc + HALF_CYC + k * BIT_CYC);
      if (k == 0) begin
        exp_bit = 1'b0;
      end else if (k > `UART_WORD_LEN) begin
        exp_bit = 1'b1;
      end else begin
        exp_bit = b1[k-1];
      end
      check_value($sformatf("txd bit %0d", k), 16'(exp_bit), 16'(txd));
      if (k == 0) begin
        read_reg(ADDR_STATUS, rd);
        check_value("status during frame", 16'h0001, rd);
        // a write while the frame is running is dropped
        write_reg(ADDR_TXDATA, 16'(~b1));
      end
    end
    wait_until_cycle(fall_cyc + HALF_CYC + (`UART_WORD_LEN + 2) * BIT_CYC);
    read_reg(ADDR_STATUS, rd);
    check_value("status after frame", 16'h0000, rd);
    end_test();

    begin_test("receive");
    repeat (4) begin
      b1 = rand_byte();
      send_frame(b1, 1'b1);
      wait_irq(1'b1, BIT_CYC);
      read_reg(ADDR_RXDATA, rd);
      check_value("rx data", 16'(b1), rd);
      check_value("irq after read", 16'h0000, 16'(irq));
    end
    end_test();

    begin_test("false_start");
    drive_rxd(1'b0, 4);
    drive_rxd(1'b1, 2 * BIT_CYC);
    @(negedge sys_clk);
    check_value("irq after glitch", 16'h0000, 16'(irq));
    read_reg(ADDR_STATUS, rd);
    check_value("status after glitch", 16'h0000, rd);
    b1 = rand_byte();
    send_frame(b1, 1'b1);
    wait_irq(1'b1, BIT_CYC);
    read_reg(ADDR_RXDATA, rd);
    check_value("rx data", 16'(b1), rd);
    end_test();

    begin_test("framing");
    b1 = rand_byte();
    send_frame(b1, 1'b0);
    wait_irq(1'b1, BIT_CYC);
    read_reg(ADDR_STATUS, rd);
    check_value("first status", 16'h000a, rd);
    read_reg(ADDR_STATUS, rd);
    check_value("second status", 16'h0002, rd);
    read_reg(ADDR_RXDATA, rd);
    check_value("rx data", 16'(b1), rd);
    end_test();

    begin_test("overrun");
    b1 = rand_byte();
    b2 = rand_byte();
    if (b2 == b1) begin
      b2 = ~b1;
    end
    send_frame(b1, 1'b1);
    send_frame(b2, 1'b1);
    wait_irq(1'b1, BIT_CYC);
    read_reg(ADDR_STATUS, rd);
    check_value("status", 16'h0006, rd);
    read_reg(ADDR_RXDATA, rd);
    check_value("rx data", 16'(b1), rd);
    check_value("irq after read", 16'h0000, 16'(irq));
    read_reg(ADDR_STATUS, rd);
    check_value("status after clear", 16'h0000, rd);
    end_test();

    fails = bound_failures();
    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, checks, errors, fails);
    if (errors == 0 && fails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (50000) @(posedge sys_clk);
    $display("simulation ran too long, the tests did not finish");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/uart_assert.sv
`default_nettype none

module uart_assert (
  input  logic                sys_clk,
  input  logic                sys_rst_l,
  input  logic                txd,
  input  logic                irq,
  input  logic                tx_start,
  input  logic                tx_busy,
  input  logic                rx_ready,
  input  uart_pkg::tx_state_t tx_state
);

  import uart_pkg::*;

  // failure counts, one per assertion, read by the testbench at the end of the run
  int tx_idle_errs    = 0;
  int ready_len_errs  = 0;
  int start_busy_errs = 0;
  int irq_rise_errs   = 0;

  tx_idle_line: assert property (@(posedge sys_clk) disable iff (!sys_rst_l)
      (tx_state == TX_IDLE) |-> txd)
    else begin
      $error("txd low while the transmitter is idle");
      tx_idle_errs = tx_idle_errs + 1;
    end

  ready_one_cycle: assert property (@(posedge sys_clk) disable iff (!sys_rst_l)
      rx_ready |=> !rx_ready)
    else begin
      $error("rx_ready stayed high for more than one cycle");
      ready_len_errs = ready_len_errs + 1;
    end

  start_not_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_l)
      tx_start |-> !tx_busy)
    else begin
      $error("tx_start pulsed while tx_busy was high");
      start_busy_errs = start_busy_errs + 1;
    end

  // irq is raised only by a received byte
  irq_after_ready: assert property (@(posedge sys_clk) disable iff (!sys_rst_l)
      $rose(irq) |-> $past(rx_ready))
    else begin
      $error("irq rose without a preceding rx_ready pulse");
      irq_rise_errs = irq_rise_errs + 1;
    end

endmodule

bind uart_top uart_assert u_chk (
  .sys_clk   (sys_clk),
  .sys_rst_l (sys_rst_l),
  .txd       (txd),
  .irq       (irq),
  .tx_start  (tx_start),
  .tx_busy   (tx_busy),
  .rx_ready  (rx_ready),
  .tx_state  (u_tx.state)
);

`default_nettype wire

// File: rtl/uart_top.sv
`default_nettype none

`include "uart_defines.svh"

module uart_top (
  input  logic                sys_clk,
  input  logic                sys_rst_l,
  input  logic                reg_wr,
  input  logic                reg_rd,
  input  uart_pkg::reg_addr_t reg_addr,
  input  logic [15:0]         reg_wdata,
  output logic [15:0]         reg_rdata,
  input  logic                rxd,
  output logic                txd,
  output logic                irq
);

  logic [`UART_DIV_W-1:0]    divisor;
  logic                      div_load;
  logic                      os_tick;
  logic                      tx_start;
  logic [`UART_WORD_LEN-1:0] tx_byte;
  logic                      tx_busy;
  logic [`UART_WORD_LEN-1:0] rx_byte;
  logic                      rx_ready;
  logic                      rx_frame_err;

  uart_regs u_regs (
    .sys_clk      (sys_clk),
    .sys_rst_l    (sys_rst_l),
    .reg_wr       (reg_wr),
    .reg_rd       (reg_rd),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata),
    .divisor      (divisor),
    .div_load     (div_load),
    .tx_start     (tx_start),
    .tx_byte      (tx_byte),
    .tx_busy      (tx_busy),
    .rx_byte      (rx_byte),
    .rx_ready     (rx_ready),
    .rx_frame_err (rx_frame_err),
    .irq          (irq)
  );

  uart_baud u_baud (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .divisor   (divisor),
    .div_load  (div_load),
    .os_tick   (os_tick)
  );

  uart_rx u_rx (
    .sys_clk      (sys_clk),
    .sys_rst_l    (sys_rst_l),
    .os_tick      (os_tick),
    .rxd          (rxd),
    .rx_byte      (rx_byte),
    .rx_ready     (rx_ready),
    .rx_frame_err (rx_frame_err)
  );

  uart_tx u_tx (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .os_tick   (os_tick),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .txd       (txd),
    .tx_busy   (tx_busy)
  );

endmodule

`default_nettype wire

// File: rtl/uart_regs.sv
`default_nettype none

`include "uart_defines.svh"

module uart_regs (
  input  logic                      sys_clk,
  input  logic                      sys_rst_l,
  input  logic                      reg_wr,
  input  logic                      reg_rd,
  input  uart_pkg::reg_addr_t       reg_addr,
  input  logic [15:0]               reg_wdata,
  output logic [15:0]               reg_rdata,
  output logic [`UART_DIV_W-1:0]    divisor,
  output logic                      div_load,
  output logic                      tx_start,
  output logic [`UART_WORD_LEN-1:0] tx_byte,
  input  logic                      tx_busy,
  input  logic [`UART_WORD_LEN-1:0] rx_byte,
  input  logic                      rx_ready,
  input  logic                      rx_frame_err,
  output logic                      irq
);

  import uart_pkg::*;

  logic                      wr_div;
  logic                      tx_accept;
  logic                      rd_rx;
  logic                      rd_status;
  logic                      rx_store;
  logic                      rx_valid;
  logic                      overrun_q;
  logic                      framing_q;
  logic [`UART_WORD_LEN-1:0] rx_data;

  assign wr_div    = reg_wr && (reg_addr == ADDR_DIV);
  // tx_start still high means tx_busy has not risen yet
  assign tx_accept = reg_wr && (reg_addr == ADDR_TXDATA) && !tx_busy && !tx_start;
  assign rd_rx     = reg_rd && (reg_addr == ADDR_RXDATA);
  assign rd_status = reg_rd && (reg_addr == ADDR_STATUS);
  assign rx_store  = rx_ready && (!rx_valid || rd_rx);

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      divisor  <= `UART_DIV_W'(`UART_DIV_RESET);
      div_load <= 1'b0;
      tx_start <= 1'b0;
    end else begin
      if (wr_div) begin
        divisor <= reg_wdata[`UART_DIV_W-1:0];
      end
      // the reload follows the write so the baud counter sees the new value
      div_load <= wr_div;
      tx_start <= tx_accept;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (tx_accept) begin
      tx_byte <= reg_wdata[`UART_WORD_LEN-1:0];
    end
    if (rx_store) begin
      rx_data <= rx_byte;
    end
  end

  // a new byte wins over a clearing read in the same cycle
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      rx_valid  <= 1'b0;
      overrun_q <= 1'b0;
      framing_q <= 1'b0;
    end else begin
      if (rx_store) begin
        rx_valid <= 1'b1;
      end else if (rd_rx) begin
        rx_valid <= 1'b0;
      end
      if (rx_ready && !rx_store) begin
        overrun_q <= 1'b1;
      end else if (rd_status) begin
        overrun_q <= 1'b0;
      end
      if (rx_ready && rx_frame_err) begin
        framing_q <= 1'b1;
      end else if (rd_status) begin
        framing_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      reg_rdata <= '0;
    end else if (reg_rd) begin
      case (reg_addr)
        ADDR_DIV:    reg_rdata <= 16'(divisor);
        ADDR_TXDATA: reg_rdata <= 16'(tx_byte);
        ADDR_RXDATA: reg_rdata <= 16'(rx_data);
        ADDR_STATUS: reg_rdata <= {12'h000, framing_q, overrun_q, rx_valid, tx_busy};
        default:     reg_rdata <= '0;
      endcase
    end
  end

  assign irq = rx_valid;

endmodule

`default_nettype wire

// File: uart_tx/uart_tx.sv
`default_nettype none

`include "uart_defines.svh"

module uart_tx (
  input  logic                      sys_clk,
  input  logic                      sys_rst_l,
  input  logic                      os_tick,
  input  logic                      tx_start,
  input  logic [`UART_WORD_LEN-1:0] tx_byte,
  output logic                      txd,
  output logic                      tx_busy
);

  import uart_pkg::*;

  localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
  localparam int BIT_W  = $clog2(`UART_WORD_LEN);

  tx_state_t                 state;
  logic [TICK_W-1:0]         tick_cnt;
  logic [BIT_W-1:0]          bit_cnt;
  logic [`UART_WORD_LEN-1:0] load_q;
  logic [`UART_WORD_LEN-1:0] shift_q;
  logic                      go;
  logic                      bit_end;

  assign go      = (state == TX_IDLE) && tx_start;
  assign bit_end = os_tick && (tick_cnt == TICK_W'(`UART_LAST_TICK));
  assign tx_busy = (state != TX_IDLE);

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      tick_cnt <= '0;
    end else if (go) begin
      tick_cnt <= '0;
    end else if (os_tick) begin
      tick_cnt <= tick_cnt + TICK_W'(1);
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      state   <= TX_IDLE;
      bit_cnt <= '0;
      txd     <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          if (tx_start) begin
            state <= TX_START;
            txd   <= 1'b0;
          end
        end
        TX_START: begin
          if (bit_end) begin
            state   <= TX_DATA;
            bit_cnt <= '0;
            txd     <= load_q[0];
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            if (bit_cnt == BIT_W'(`UART_WORD_LEN - 1)) begin
              state <= TX_STOP;
              txd   <= 1'b1;
            end else begin
              bit_cnt <= bit_cnt + BIT_W'(1);
              txd     <= shift_q[0];
            end
          end
        end
        TX_STOP: begin
          if (bit_end) begin
            state <= TX_IDLE;
          end
        end
        default: begin
          state <= TX_IDLE;
          txd   <= 1'b1;
        end
      endcase
    end
  end

  // shift_q always holds the bits still to be sent after the current one
  always_ff @(posedge sys_clk) begin
    if (go) begin
      load_q <= tx_byte;
    end
    if (state == TX_START && bit_end) begin
      shift_q <= load_q >> 1;
    end else if (state == TX_DATA && bit_end) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

`default_nettype wire

// File: uart_rx/uart_rx.sv
`default_nettype none

`include "uart_defines.svh"

module uart_rx (
  input  logic                      sys_clk,
  input  logic                      sys_rst_l,
  input  logic                      os_tick,
  input  logic                      rxd,
  output logic [`UART_WORD_LEN-1:0] rx_byte,
  output logic                      rx_ready,
  output logic                      rx_frame_err
);

  import uart_pkg::*;

  localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
  localparam int BIT_W  = $clog2(`UART_WORD_LEN + 1);

  logic                      rxd_meta;
  logic                      rxd_s;
  logic [TICK_W-1:0]         tick_cnt;
  logic [BIT_W-1:0]          bit_cnt;
  logic [`UART_WORD_LEN-1:0] shift_q;
  rx_state_t                 state;
  rx_state_t                 next_state;
  logic                      tick_clr;
  logic                      shift_en;
  logic                      bit_inc;
  logic                      bit_clr;
  logic                      ready_in;
  logic                      stop_bad;

  // the line idles high, so the synchronizer resets to one
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      rxd_meta <= 1'b1;
      rxd_s    <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_s    <= rxd_meta;
    end
  end

  // free running within a frame, wraps every 16 ticks
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      tick_cnt <= '0;
    end else if (tick_clr) begin
      tick_cnt <= '0;
    end else if (os_tick) begin
      tick_cnt <= tick_cnt + TICK_W'(1);
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      bit_cnt <= '0;
    end else if (bit_clr) begin
      bit_cnt <= '0;
    end else if (bit_inc) begin
      bit_cnt <= bit_cnt + BIT_W'(1);
    end
  end

  // lsb arrives first and ends up at bit 0 after the last shift
  always_ff @(posedge sys_clk) begin
    if (shift_en) begin
      shift_q <= {rxd_s, shift_q[`UART_WORD_LEN-1:1]};
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      state <= RX_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    tick_clr   = 1'b0;
    shift_en   = 1'b0;
    bit_inc    = 1'b0;
    bit_clr    = 1'b0;
    ready_in   = 1'b0;
    stop_bad   = 1'b0;
    case (state)
      RX_IDLE: begin
        bit_clr = 1'b1;
        // the detecting tick counts as tick 0 of the start cell
        if (os_tick && !rxd_s) begin
          next_state = RX_START;
        end else begin
          tick_clr = 1'b1;
        end
      end
      RX_START: begin
        if (os_tick && tick_cnt == TICK_W'(`UART_MID_TICK)) begin
          tick_clr = 1'b1;
          if (rxd_s) begin
            next_state = RX_IDLE;
          end else begin
            next_state = RX_WAIT;
          end
        end
      end
      RX_WAIT: begin
        // 16 ticks after the previous sample point
        if (os_tick && tick_cnt == TICK_W'(`UART_LAST_TICK)) begin
          if (bit_cnt == BIT_W'(`UART_WORD_LEN)) begin
            next_state = RX_STOP;
          end else begin
            next_state = RX_SAMPLE;
          end
        end
      end
      RX_SAMPLE: begin
        shift_en   = 1'b1;
        bit_inc    = 1'b1;
        next_state = RX_WAIT;
      end
      RX_STOP: begin
        ready_in   = 1'b1;
        stop_bad   = !rxd_s;
        next_state = RX_IDLE;
      end
      default: begin
        next_state = RX_IDLE;
      end
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      rx_ready     <= 1'b0;
      rx_frame_err <= 1'b0;
    end else begin
      rx_ready     <= ready_in;
      rx_frame_err <= ready_in && stop_bad;
    end
  end

  assign rx_byte = shift_q;

endmodule

`default_nettype wire

// File: rtl/uart_baud.sv
`default_nettype none

`include "uart_defines.svh"

module uart_baud (
  input  logic                   sys_clk,
  input  logic                   sys_rst_l,
  input  logic [`UART_DIV_W-1:0] divisor,
  input  logic                   div_load,
  output logic                   os_tick
);

  logic [`UART_DIV_W-1:0] div_cnt;

  // counts divisor down to one, so the tick period is divisor cycles
  // a divisor of zero behaves like one
  always_ff @(posedge sys_clk) begin
    if (!sys_rst_l) begin
      div_cnt <= `UART_DIV_W'(`UART_DIV_RESET);
      os_tick <= 1'b0;
    end else if (div_load) begin
      div_cnt <= divisor;
      os_tick <= 1'b0;
    end else if (div_cnt <= `UART_DIV_W'(1)) begin
      div_cnt <= divisor;
      os_tick <= 1'b1;
    end else begin
      div_cnt <= div_cnt - `UART_DIV_W'(1);
      os_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: common/uart_pkg.sv
`default_nettype none

package uart_pkg;

  // receiver states, the start cell is checked at its middle before data sampling
  typedef enum logic [2:0] {
    RX_IDLE   = 3'd0,
    RX_START  = 3'd1,
    RX_WAIT   = 3'd2,
    RX_SAMPLE = 3'd3,
    RX_STOP   = 3'd4
  } rx_state_t;

  typedef enum logic [1:0] {
    TX_IDLE  = 2'd0,
    TX_START = 2'd1,
    TX_DATA  = 2'd2,
    TX_STOP  = 2'd3
  } tx_state_t;

  // host register map
  typedef enum logic [1:0] {
    ADDR_DIV    = 2'd0,
    ADDR_TXDATA = 2'd1,
    ADDR_RXDATA = 2'd2,
    ADDR_STATUS = 2'd3
  } reg_addr_t;

endpackage

`default_nettype wire

// File: common/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// frame format
`define UART_WORD_LEN 8

// ticks per bit cell
`define UART_OVERSAMPLE 16

// tick index of the bit middle, where the start bit is checked
`define UART_MID_TICK 7

// last tick of a bit cell
`define UART_LAST_TICK 15

// baud divisor after reset
`define UART_DIV_RESET 4

`define UART_DIV_W 16

`endif
